// File: Makefile
# Verilator build for the UMI width converter testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_umi_fifo_width
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/tb_umi_fifo_width.sv
//####################
// UMI width converter testbench
// Replays packets from the vector file and checks every narrow beat
//####################

`timescale 1ns/1ps
`default_nettype none

`include "umi_cfg.svh"

module tb_umi_fifo_width;

   import umi_pkg::*;

   localparam int VEC_WORDS = 128;  // Header, packets and beats, one word each field
   localparam int B2B_PKTS  = 3;    // Last packets go back to back
   localparam int STALL_LO  = 12;   // Sink held off in this cycle window
   localparam int STALL_HI  = 24;

   logic       umi_in_clk;
   logic       umi_in_nreset;
   logic       umi_in_valid;
   umi_cmd_t   umi_in_cmd;
   umi_addr_t  umi_in_dstaddr;
   umi_addr_t  umi_in_srcaddr;
   umi_idata_t umi_in_data;
   logic       umi_in_ready;
   logic       umi_out_valid;
   umi_cmd_t   umi_out_cmd;
   umi_addr_t  umi_out_dstaddr;
   umi_addr_t  umi_out_srcaddr;
   umi_odata_t umi_out_data;
   logic       umi_out_ready;

   logic [`UMI_IDW-1:0] vec_mem [0:VEC_WORDS-1];

   integer seed   = 32'h3186_247b;
   int     n_pkt  = 0;
   int     n_exp  = 0;
   int     exp_base;
   int     got    = 0;
   int     errors = 0;
   int     cycles = 0;
   int     limit  = 1000000;  // Replaced once the vectors are loaded

   umi_fifo_width u_dut
     (.umi_in_clk      (umi_in_clk),
      .umi_in_nreset   (umi_in_nreset),
      .umi_in_valid    (umi_in_valid),
      .umi_in_cmd      (umi_in_cmd),
      .umi_in_dstaddr  (umi_in_dstaddr),
      .umi_in_srcaddr  (umi_in_srcaddr),
      .umi_in_data     (umi_in_data),
      .umi_in_ready    (umi_in_ready),
      .umi_out_valid   (umi_out_valid),
      .umi_out_cmd     (umi_out_cmd),
      .umi_out_dstaddr (umi_out_dstaddr),
      .umi_out_srcaddr (umi_out_srcaddr),
      .umi_out_data    (umi_out_data),
      .umi_out_ready   (umi_out_ready));

   always #2 umi_in_clk = ~umi_in_clk;

   //####################
   // Compare tasks
   //####################

   task automatic check_cmd(input string name, input umi_cmd_t act, input umi_cmd_t exp);
      if (act !== exp)
      begin
         errors++;
         $display("Fail at %0t ns: beat %0d %s is %h, expected %h", $time, got, name, act, exp);
      end
   endtask

   task automatic check_addr(input string name, input umi_addr_t act, input umi_addr_t exp);
      if (act !== exp)
      begin
         errors++;
         $display("Fail at %0t ns: beat %0d %s is %h, expected %h", $time, got, name, act, exp);
      end
   endtask

   task automatic check_data(input string name, input umi_odata_t act, input umi_odata_t exp);
      if (act !== exp)
      begin
         errors++;
         $display("Fail at %0t ns: beat %0d %s is %h, expected %h", $time, got, name, act, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp)
      begin
         errors++;
         $display("Fail at %0t ns: %s is %b, expected %b", $time, name, act, exp);
      end
   endtask

   //####################
   // Driver helpers
   //####################

   task automatic insert_idle(input int n);
      repeat (n)
      begin
         @(negedge umi_in_clk);
         umi_in_valid = 1'b0;
      end
   endtask

   // Present one packet and hold it until the DUT takes it
   task automatic offer_packet(input int idx);
      int b;
      b = 2 + 4 * idx;
      @(negedge umi_in_clk);
      umi_in_valid   = 1'b1;
      umi_in_cmd     = umi_cmd_t'(vec_mem[b][`UMI_CW-1:0]);
      umi_in_dstaddr = umi_addr_t'(vec_mem[b+1][`UMI_AW-1:0]);
      umi_in_srcaddr = umi_addr_t'(vec_mem[b+2][`UMI_AW-1:0]);
      umi_in_data    = vec_mem[b+3];
      @(posedge umi_in_clk);
      while (!umi_in_ready)
         @(posedge umi_in_clk);
   endtask

   task automatic finish_run(input bit timed_out);
      int missing;
      missing = (got < n_exp) ? n_exp - got : 0;
      $display("Errors: %0d, missing beats: %0d", errors, missing);
      if (!timed_out && errors == 0 && missing == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   endtask

   //####################
   // Stimulus
   //####################

   initial
   begin
      umi_in_clk     = 1'b0;
      umi_in_nreset  = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      umi_out_ready  = 1'b0;

      $readmemh("bench/umi_width_vectors.txt", vec_mem);
      n_pkt    = int'(vec_mem[0][31:0]);
      n_exp    = int'(vec_mem[1][31:0]);
      exp_base = 2 + 4 * n_pkt;
      limit    = n_exp * 8 + 200;

      repeat (4) @(posedge umi_in_clk);
      @(negedge umi_in_clk);
      umi_in_nreset = 1'b1;

      // Idle state before any packet
      check_flag("umi_out_valid", umi_out_valid, 1'b0);
      check_flag("umi_in_ready", umi_in_ready, 1'b1);

      for (int i = 0; i < n_pkt; i++)
      begin
         if (i < n_pkt - B2B_PKTS)
            insert_idle($random(seed) & 3);
         offer_packet(i);
      end
      @(negedge umi_in_clk);
      umi_in_valid = 1'b0;

      wait (got >= n_exp);
      repeat (10) @(posedge umi_in_clk);  // Room for any extra beat
      finish_run(1'b0);
   end

   // Random sink stalls plus one long stall that fills the FIFO
   always @(negedge umi_in_clk)
   begin
      if (cycles < 6)
         umi_out_ready = 1'b0;
      else if (cycles >= STALL_LO && cycles < STALL_HI)
         umi_out_ready = 1'b0;
      else
         umi_out_ready = ($random(seed) & 3) != 0;
   end

   //####################
   // Monitor
   //####################

   always @(posedge umi_in_clk)
   begin
      int b;
      if (umi_in_nreset && umi_out_valid && umi_out_ready)
      begin
         if (got < n_exp)
         begin
            b = exp_base + 4 * got;
            check_cmd("cmd", umi_out_cmd, umi_cmd_t'(vec_mem[b][`UMI_CW-1:0]));
            check_addr("dstaddr", umi_out_dstaddr, umi_addr_t'(vec_mem[b+1][`UMI_AW-1:0]));
            check_addr("srcaddr", umi_out_srcaddr, umi_addr_t'(vec_mem[b+2][`UMI_AW-1:0]));
            check_data("data", umi_out_data, umi_odata_t'(vec_mem[b+3][`UMI_ODW-1:0]));
         end
         else
         begin
            errors++;
            $display("Extra beat at %0t ns beyond the %0d expected", $time, n_exp);
         end
         got++;
      end
   end

   // Run limit
   always @(posedge umi_in_clk)
   begin
      cycles = cycles + 1;
      if (cycles >= limit)
      begin
         $display("Timeout: run took more than %0d cycles, %0d of %0d beats seen",
                  limit, got, n_exp);
         finish_run(1'b1);
      end
   end

endmodule

`default_nettype wire

// File: bench/umi_width_vectors.txt
// Header: input packet count, expected beat count
// Packet: cmd dstaddr srcaddr, then 256-bit data on the next line; beat: cmd dstaddr srcaddr data
00000007 00000011

// Packet 0, size 3 len 0, one beat
a5c30064 0000000010000000 0000000020000000
ffffffffffffffff_eeeeeeeeeeeeeeee_dddddddddddddddd_00000000cafef00d
// Packet 1, size 3 len 3, four beats
12340363 0000000100000000 0000000200001000
1111111111111103_1111111111111102_1111111111111101_1111111111111100
// Packet 2, size 0 len 15, two beats of len 7
beef0f05 0000000000003000 0000000000004000
aaaaaaaaaaaaaaaa_bbbbbbbbbbbbbbbb_0f0e0d0c0b0a0908_0706050403020100
// Packet 3, size 1 len 5, beats of len 3 and len 1
7e010522 00000000abcd0010 0000000012340020
9999999999999999_8888888888888888_2222222222222222_1111111111111111
// Packet 4, size 2 len 1, one beat
00420141 0000000000000100 0000000000000200
7777777777777777_6666666666666666_5555555555555555_00000000deadbeef
// Packet 5, size 2 len 7, four beats of len 1
ffff075f ffffffff00000000 8000000000000000
a000000000000003_a000000000000002_a000000000000001_a000000000000000
// Packet 6, size 3 len 2, three beats
00010263 0000000000005000 0000000000006000
c3c3c3c3c3c3c3c3_c2c2c2c2c2c2c2c2_c1c1c1c1c1c1c1c1_c0c0c0c0c0c0c0c0

// Expected beats in arrival order
a5c30064 0000000010000000 0000000020000000 00000000cafef00d
12340063 0000000100000000 0000000200001000 1111111111111100
12340063 0000000100000008 0000000200001008 1111111111111101
12340063 0000000100000010 0000000200001010 1111111111111102
12340063 0000000100000018 0000000200001018 1111111111111103
beef0705 0000000000003000 0000000000004000 0706050403020100
beef0705 0000000000003008 0000000000004008 0f0e0d0c0b0a0908
7e010322 00000000abcd0010 0000000012340020 1111111111111111
7e010122 00000000abcd0018 0000000012340028 2222222222222222
00420141 0000000000000100 0000000000000200 00000000deadbeef
ffff015f ffffffff00000000 8000000000000000 a000000000000000
ffff015f ffffffff00000008 8000000000000008 a000000000000001
ffff015f ffffffff00000010 8000000000000010 a000000000000002
ffff015f ffffffff00000018 8000000000000018 a000000000000003
00010063 0000000000005000 0000000000006000 c0c0c0c0c0c0c0c0
00010063 0000000000005008 0000000000006008 c1c1c1c1c1c1c1c1
00010063 0000000000005010 0000000000006010 c2c2c2c2c2c2c2c2

// File: hw/umi_fifo_sync.sv
//####################
// UMI queue stage
// Synchronous FIFO of narrow transactions
//####################

`timescale 1ns/1ps
`default_nettype none

`include "umi_cfg.svh"

module umi_fifo_sync
  (
   input  wire                   umi_in_clk,
   input  wire                   umi_in_nreset,
   // Write side
   input  wire                   beat_valid,
   input  umi_pkg::umi_cmd_t     beat_cmd,
   input  umi_pkg::umi_addr_t    beat_dstaddr,
   input  umi_pkg::umi_addr_t    beat_srcaddr,
   input  umi_pkg::umi_odata_t   beat_data,
   output logic                  fifo_full,
   // Read side
   input  wire                   umi_out_ready,
   output logic                  umi_out_valid,
   output umi_pkg::umi_cmd_t     umi_out_cmd,
   output umi_pkg::umi_addr_t    umi_out_dstaddr,
   output umi_pkg::umi_addr_t    umi_out_srcaddr,
   output umi_pkg::umi_odata_t   umi_out_data
   );

   localparam int DEPTH = `UMI_FIFO_DEPTH;
   localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNTW  = $clog2(DEPTH + 1);
   localparam int EW    = `UMI_CW + 2 * `UMI_AW + `UMI_ODW;  // Packed entry

   logic [EW-1:0]   mem [0:DEPTH-1];
   logic [PW-1:0]   wr_ptr;
   logic [PW-1:0]   rd_ptr;
   logic [CNTW-1:0] count;
   logic            empty;
   logic            wr_en;
   logic            rd_en;

   assign fifo_full = (count == CNTW'(DEPTH));
   assign empty     = (count == '0);

   assign wr_en = beat_valid & ~fifo_full;
   assign rd_en = umi_out_ready & ~empty;

   //####################
   // Pointers and count
   //####################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
         if (rd_en)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
         if (wr_en & ~rd_en)
            count <= count + CNTW'(1);
         else if (rd_en & ~wr_en)
            count <= count - CNTW'(1);  // Simultaneous push and pop keeps count
      end
   end

   // Storage
   always_ff @(posedge umi_in_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= {beat_data, beat_srcaddr, beat_dstaddr, beat_cmd};
   end

   //####################
   // Read side
   //####################

   assign umi_out_valid = ~empty;
   assign {umi_out_data, umi_out_srcaddr, umi_out_dstaddr, umi_out_cmd} = mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/umi_fifo_width.sv
//####################
// UMI width converter
// Splits wide packets into narrow beats and queues them
//####################

`timescale 1ns/1ps
`default_nettype none

module umi_fifo_width
  (
   input  wire                   umi_in_clk,
   input  wire                   umi_in_nreset,
   // Wide input
   input  wire                   umi_in_valid,
   input  umi_pkg::umi_cmd_t     umi_in_cmd,
   input  umi_pkg::umi_addr_t    umi_in_dstaddr,
   input  umi_pkg::umi_addr_t    umi_in_srcaddr,
   input  umi_pkg::umi_idata_t   umi_in_data,
   output logic                  umi_in_ready,
   // Narrow output
   output logic                  umi_out_valid,
   output umi_pkg::umi_cmd_t     umi_out_cmd,
   output umi_pkg::umi_addr_t    umi_out_dstaddr,
   output umi_pkg::umi_addr_t    umi_out_srcaddr,
   output umi_pkg::umi_odata_t   umi_out_data,
   input  wire                   umi_out_ready
   );

   import umi_pkg::*;

   // Split stage to queue stage
   logic       beat_valid;
   umi_cmd_t   beat_cmd;
   umi_addr_t  beat_dstaddr;
   umi_addr_t  beat_srcaddr;
   umi_odata_t beat_data;
   logic       fifo_full;

   umi_split u_split
     (.umi_in_clk     (umi_in_clk),
      .umi_in_nreset  (umi_in_nreset),
      .umi_in_valid   (umi_in_valid),
      .umi_in_cmd     (umi_in_cmd),
      .umi_in_dstaddr (umi_in_dstaddr),
      .umi_in_srcaddr (umi_in_srcaddr),
      .umi_in_data    (umi_in_data),
      .umi_in_ready   (umi_in_ready),
      .fifo_full      (fifo_full),
      .beat_valid     (beat_valid),
      .beat_cmd       (beat_cmd),
      .beat_dstaddr   (beat_dstaddr),
      .beat_srcaddr   (beat_srcaddr),
      .beat_data      (beat_data));

   umi_fifo_sync u_fifo
     (.umi_in_clk      (umi_in_clk),
      .umi_in_nreset   (umi_in_nreset),
      .beat_valid      (beat_valid),
      .beat_cmd        (beat_cmd),
      .beat_dstaddr    (beat_dstaddr),
      .beat_srcaddr    (beat_srcaddr),
      .beat_data       (beat_data),
      .fifo_full       (fifo_full),
      .umi_out_ready   (umi_out_ready),
      .umi_out_valid   (umi_out_valid),
      .umi_out_cmd     (umi_out_cmd),
      .umi_out_dstaddr (umi_out_dstaddr),
      .umi_out_srcaddr (umi_out_srcaddr),
      .umi_out_data    (umi_out_data));

endmodule

`default_nettype wire

// File: hw/umi_pkg.sv
//####################
// UMI width converter types
// Vector typedefs for the command, address, data and field widths
//####################

`default_nettype none

`include "umi_cfg.svh"

package umi_pkg;

   // Bus vectors
   typedef logic [`UMI_CW-1:0]  umi_cmd_t;
   typedef logic [`UMI_AW-1:0]  umi_addr_t;
   typedef logic [`UMI_IDW-1:0] umi_idata_t;  // Wide side
   typedef logic [`UMI_ODW-1:0] umi_odata_t;  // Narrow side

   // Command fields
   // opcode [4:0], size [7:5], len [15:8], rest carried as is
   typedef logic [7:0] umi_len_t;   // Word count minus one
   typedef logic [2:0] umi_size_t;  // Log2 of word bytes

endpackage

`default_nettype wire

// File: hw/umi_split.sv
//####################
// UMI split stage
// Latches a wide packet and emits output-width beats
//####################

`timescale 1ns/1ps
`default_nettype none

`include "umi_cfg.svh"

module umi_split
  (
   input  wire                   umi_in_clk,
   input  wire                   umi_in_nreset,
   // Wide input side
   input  wire                   umi_in_valid,
   input  umi_pkg::umi_cmd_t     umi_in_cmd,
   input  umi_pkg::umi_addr_t    umi_in_dstaddr,
   input  umi_pkg::umi_addr_t    umi_in_srcaddr,
   input  umi_pkg::umi_idata_t   umi_in_data,
   output logic                  umi_in_ready,
   // Narrow beat toward the queue
   input  wire                   fifo_full,
   output logic                  beat_valid,
   output umi_pkg::umi_cmd_t     beat_cmd,
   output umi_pkg::umi_addr_t    beat_dstaddr,
   output umi_pkg::umi_addr_t    beat_srcaddr,
   output umi_pkg::umi_odata_t   beat_data
   );

   import umi_pkg::*;

   localparam int OBYTES = `UMI_ODW / 8;  // Bytes per output beat

   // Hold register for the rest of a packet
   logic       hold;
   umi_cmd_t   hold_cmd;
   umi_addr_t  hold_dstaddr;
   umi_addr_t  hold_srcaddr;
   umi_idata_t hold_data;

   // Current beat source
   umi_cmd_t   cur_cmd;
   umi_addr_t  cur_dstaddr;
   umi_addr_t  cur_srcaddr;
   umi_idata_t cur_data;
   umi_size_t  cur_size;
   umi_len_t   cur_len;

   // Length arithmetic
   logic [8:0] words_left;
   logic [8:0] wpb_raw;
   logic [8:0] wpb;
   logic       more;
   umi_len_t   beat_len;
   umi_len_t   rest_len;
   umi_addr_t  addr_step;
   logic       beat_write;

   //####################
   // Beat select
   //####################

   assign cur_cmd     = hold ? hold_cmd     : umi_in_cmd;
   assign cur_dstaddr = hold ? hold_dstaddr : umi_in_dstaddr;
   assign cur_srcaddr = hold ? hold_srcaddr : umi_in_srcaddr;
   assign cur_data    = hold ? hold_data    : umi_in_data;

   assign cur_size = cur_cmd[7:5];
   assign cur_len  = cur_cmd[15:8];

   // Words that fit one output beat, never below one
   assign wpb_raw = 9'(OBYTES >> cur_size);
   assign wpb     = (wpb_raw == 9'd0) ? 9'd1 : wpb_raw;

   assign words_left = {1'b0, cur_len} + 9'd1;
   assign more       = words_left > wpb;

   // Len of this beat and of what stays behind
   assign beat_len = more ? umi_len_t'(wpb - 9'd1) : cur_len;
   assign rest_len = umi_len_t'(words_left - wpb - 9'd1);

   assign addr_step = umi_addr_t'(wpb) << cur_size;  // 8 bytes for size <= 3

   //####################
   // Beat outputs
   //####################

   assign beat_valid   = hold | umi_in_valid;
   assign beat_cmd     = {cur_cmd[`UMI_CW-1:16], beat_len, cur_cmd[7:0]};
   assign beat_dstaddr = cur_dstaddr;
   assign beat_srcaddr = cur_srcaddr;
   assign beat_data    = cur_data[`UMI_ODW-1:0];

   assign beat_write = beat_valid & ~fifo_full;

   // No new packet while splitting or while the queue is full
   assign umi_in_ready = ~hold & ~fifo_full;

   //####################
   // Hold state
   //####################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         hold <= 1'b0;
      end
      else if (beat_write)
      begin
         hold <= more;  // Clears on the last beat
      end
   end

   // Remainder of the packet after each written beat
   always_ff @(posedge umi_in_clk)
   begin
      if (beat_write)
      begin
         hold_cmd     <= {cur_cmd[`UMI_CW-1:16], rest_len, cur_cmd[7:0]};
         hold_dstaddr <= cur_dstaddr + addr_step;
         hold_srcaddr <= cur_srcaddr + addr_step;
         hold_data    <= cur_data >> `UMI_ODW;
      end
   end

endmodule

`default_nettype wire

// File: include/umi_cfg.svh
//####################
// UMI width converter configuration
// Bus widths and queue depth
//####################

`ifndef UMI_CFG_SVH
`define UMI_CFG_SVH

// Bus widths in bits
`define UMI_CW  32    // Command
`define UMI_AW  64    // Source and destination address
`define UMI_IDW 256   // Wide input data
`define UMI_ODW 64    // Narrow output data

// Queue stage
`define UMI_FIFO_DEPTH 4

`endif

// File: tb.f
+incdir+include
hw/umi_pkg.sv
hw/umi_split.sv
hw/umi_fifo_sync.sv
hw/umi_fifo_width.sv
bench/tb_umi_fifo_width.sv
